/* dv/tb_dmem.sv */
`timescale 1ns/1ps

module tb_dmem
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              req_i,
    input  logic              we_i,
    input  logic [xlen-1:0]   addr_i,
    input  logic [xlen-1:0]   wdata_i,
    input  logic [nbytes-1:0] be_i,
    output logic              ack_o,
    output logic [xlen-1:0]   rdata_o,
    output int                acc_cnt_o,     // accesses served so far
    output logic [xlen-1:0]   last_addr_o,
    output logic [xlen-1:0]   last_wdata_o,
    output logic [nbytes-1:0] last_be_o,
    output logic              last_we_o
);

    localparam int words = 64;

    logic [xlen-1:0] mem [words];
    int              seed = 32'hde64_6f49;
    int              delay;
    int              idx;

    initial begin : responder
        // every byte carries its own address, top bit flipped in lanes 1 and 3
        for (int i = 0; i < words; i++) begin
            mem[i] = {8'(4 * i + 3), 8'(4 * i + 2), 8'(4 * i + 1), 8'(4 * i)} ^ 32'h8000_8000;
        end
        ack_o        = 1'b0;
        rdata_o      = '0;
        acc_cnt_o    = 0;
        last_addr_o  = '0;
        last_wdata_o = '0;
        last_be_o    = '0;
        last_we_o    = 1'b0;
        forever begin
            @(negedge clk);
            if (req_i && !ack_o) begin
                delay = 1 + int'($unsigned($random(seed)) % 4);  // 1 to 4 cycles
                repeat (delay) @(negedge clk);
                idx = int'(addr_i[7:2]);
                for (int b = 0; b < nbytes; b++) begin
                    if (we_i && be_i[b]) begin
                        mem[idx][8*b +: 8] = wdata_i[8*b +: 8];
                    end
                end
                rdata_o      = mem[idx];
                last_addr_o  = addr_i;
                last_wdata_o = wdata_i;
                last_be_o    = be_i;
                last_we_o    = we_i;
                acc_cnt_o    = acc_cnt_o + 1;
                ack_o        = 1'b1;
                while (req_i) @(negedge clk);  // hold ack until req drops
                ack_o = 1'b0;
            end
        end
    end

endmodule : tb_dmem

/* dv/tb_lsu.sv */
`timescale 1ns/1ps

module tb_lsu
    import lsu_pkg::*;
();

    localparam int clk_period    = 40;
    localparam int max_ops       = 40;
    localparam int cycles_per_op = 20;
    localparam int mem_settle    = 6;   // longest memory delay plus the request cycles

    typedef struct packed {
        logic [xlen-1:0]       data;
        logic [reg_addr_w-1:0] rd;
        logic                  we;
        logic                  trap;
        logic [order_w-1:0]    order;
    } wb_rec_t;

    logic clk;
    logic rst;
    logic issue_req_i;
    logic issue_ack_o;
    lsu_op_e kind_i;
    mem_width_e width_i;
    wb_sel_e wb_sel_i;
    logic [reg_addr_w-1:0] rd_i;
    logic reg_we_i;
    logic [xlen-1:0] pc_i;
    logic [xlen-1:0] addr_i;
    logic [xlen-1:0] exe_data_i;
    logic [xlen-1:0] store_data_i;
    logic dmem_req_o;
    logic dmem_we_o;
    logic [xlen-1:0] dmem_addr_o;
    logic [xlen-1:0] dmem_wdata_o;
    logic [nbytes-1:0] dmem_be_o;
    logic dmem_ack_i;
    logic [xlen-1:0] dmem_rdata_i;
    logic wb_valid_o;
    logic wb_we_o;
    logic [reg_addr_w-1:0] wb_rd_o;
    logic [xlen-1:0] wb_data_o;
    logic [order_w-1:0] wb_order_o;
    logic wb_trap_o;
    int acc_cnt;
    logic [xlen-1:0] last_addr;
    logic [xlen-1:0] last_wdata;
    logic [nbytes-1:0] last_be;
    logic last_we;

    int                 seed = 32'hde64_6f49;
    int                 errors = 0;
    int                 cyc = 0;
    int                 ack_cyc;
    int                 ack_wait;   // negedges from req to ack
    int                 wb_cyc;
    logic [order_w-1:0] next_order = '0;
    wb_rec_t            rec;
    wb_rec_t            got_q [$];
    wb_rec_t            exp_q [$];
    int                 cyc_q [$];

    lsu_top i_dut (.*);

    tb_dmem i_dmem (
        .clk          (clk),
        .req_i        (dmem_req_o),
        .we_i         (dmem_we_o),
        .addr_i       (dmem_addr_o),
        .wdata_i      (dmem_wdata_o),
        .be_i         (dmem_be_o),
        .ack_o        (dmem_ack_i),
        .rdata_o      (dmem_rdata_i),
        .acc_cnt_o    (acc_cnt),
        .last_addr_o  (last_addr),
        .last_wdata_o (last_wdata),
        .last_be_o    (last_be),
        .last_we_o    (last_we)
    );

    initial begin : clk_gen
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    always @(negedge clk) begin : collect
        if (wb_valid_o) begin
            rec.data  = wb_data_o;
            rec.rd    = wb_rd_o;
            rec.we    = wb_we_o;
            rec.trap  = wb_trap_o;
            rec.order = wb_order_o;
            got_q.push_back(rec);
            cyc_q.push_back(cyc);
        end
    end

    task automatic check_data(input string what, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rd(input string what, input logic [reg_addr_w-1:0] got,
                            input logic [reg_addr_w-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_order(input string what, input logic [order_w-1:0] got,
                               input logic [order_w-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_be(input string what, input logic [nbytes-1:0] got,
                            input logic [nbytes-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // illegal funct3, unsigned stores and halves crossing the word
    function automatic logic predict_trap(lsu_op_e k, mem_width_e w, logic [1:0] off);
        logic legal_w;
        legal_w = (w == lb) || (w == lh) || (w == lw)
               || (k == op_load && (w == lbu || w == lhu));
        if (k == op_none) begin
            return 1'b0;
        end
        return !legal_w || ((w == lh || w == lhu) && off == 2'd3);
    endfunction

    function automatic logic [xlen-1:0] load_value(mem_width_e w, logic [xlen-1:0] a);
        logic [xlen-1:0] word;
        word = i_dmem.mem[a[7:2]] >> (8 * a[1:0]);  // wanted bytes to the bottom
        case (w)
            lb:      return {{24{word[7]}}, word[7:0]};
            lbu:     return {24'h0, word[7:0]};
            lh:      return {{16{word[15]}}, word[15:0]};
            lhu:     return {16'h0, word[15:0]};
            default: return word;
        endcase
    endfunction

    // four-phase issue with the expected writeback queued first
    task automatic issue_op(input lsu_op_e k, input mem_width_e w, input wb_sel_e s,
                            input logic [xlen-1:0] a, input logic [xlen-1:0] d);
        wb_rec_t exp;
        @(negedge clk);
        kind_i       = k;
        width_i      = w;
        wb_sel_i     = s;
        rd_i         = reg_addr_w'($random(seed));
        reg_we_i     = (k != op_store);
        pc_i         = $random(seed);
        addr_i       = a;
        exe_data_i   = $random(seed);
        store_data_i = d;
        issue_req_i  = 1'b1;
        exp.trap     = predict_trap(k, w, a[1:0]);
        exp.we       = reg_we_i && !exp.trap;
        exp.rd       = rd_i;
        exp.order    = next_order;
        next_order   = next_order + order_w'(1);
        case (s)
            wb_mem_data:  exp.data = load_value(w, a);
            wb_pc_plus_4: exp.data = pc_i + 32'd4;
            default:      exp.data = exe_data_i;
        endcase
        exp_q.push_back(exp);
        ack_wait = 0;
        do begin
            @(negedge clk);
            ack_wait++;
        end while (!issue_ack_o);
        ack_cyc     = cyc;
        issue_req_i = 1'b0;
        while (issue_ack_o) @(negedge clk);
    endtask

    task automatic check_next(input string tag);
        wb_rec_t got;
        wb_rec_t exp;
        while (got_q.size() == 0) @(negedge clk);
        got    = got_q.pop_front();
        exp    = exp_q.pop_front();
        wb_cyc = cyc_q.pop_front();
        check_data({tag, " data"}, got.data, exp.data);
        check_rd({tag, " rd"}, got.rd, exp.rd);
        check_flag({tag, " we"}, got.we, exp.we);
        check_flag({tag, " trap"}, got.trap, exp.trap);
        check_order({tag, " order"}, got.order, exp.order);
    endtask

    task automatic test_non_mem();
        wb_sel_e sel [2] = '{wb_exe_data, wb_pc_plus_4};
        for (int i = 0; i < 2; i++) begin
            issue_op(op_none, lw, sel[i], 32'h0, 32'h0);
            check_next("non-mem");
            // writeback registers on the clock after the capture edge
            if (wb_cyc - ack_cyc != 1) begin
                errors++;
                $display("ERR at %0t ns: non-mem latency %0d", $time, wb_cyc - ack_cyc);
            end
        end
    endtask

    task automatic test_stores();
        mem_width_e st_w [3] = '{sb, sh, sw};
        logic [xlen-1:0] a;
        logic [xlen-1:0] d;
        int n;
        for (int wi = 0; wi < 3; wi++) begin
            n = 1 << wi;
            for (int off = 0; off + n <= nbytes; off++) begin
                a = 32'h40 + 16 * wi + off;
                d = $random(seed);
                issue_op(op_store, st_w[wi], wb_exe_data, a, d);
                check_next("store");
                check_data("store addr", last_addr, {a[xlen-1:2], 2'b00});
                check_be("store lanes", last_be, nbytes'(((1 << n) - 1) << off));
                check_data("store data", last_wdata, d << (8 * off));
                check_flag("store we", last_we, 1'b1);
            end
        end
    endtask

    task automatic test_loads();
        mem_width_e ld_w [5] = '{lb, lbu, lh, lhu, lw};
        int ld_n [5] = '{1, 1, 2, 2, 4};
        for (int wi = 0; wi < 5; wi++) begin
            for (int off = 0; off + ld_n[wi] <= nbytes; off++) begin
                issue_op(op_load, ld_w[wi], wb_mem_data, 32'h20 + 36 * wi + off, 32'h0);
                check_next("load");
            end
        end
    endtask

    task automatic test_traps();
        lsu_op_e kinds [5] = '{op_load, op_load, op_store, op_load, op_store};
        mem_width_e widths [5] = '{mem_width_e'(3'b011), mem_width_e'(3'b110), lbu, lh, sh};
        int offs [5] = '{0, 1, 0, 3, 3};
        int cnt0;
        for (int i = 0; i < 5; i++) begin
            cnt0 = acc_cnt;
            issue_op(kinds[i], widths[i], wb_exe_data, 32'h30 + offs[i], 32'h1234_5678);
            check_next("trap");
            repeat (mem_settle) @(negedge clk);  // a stray request would be served by now
            check_flag("trap left memory alone", acc_cnt == cnt0, 1'b1);
        end
    endtask

    // second op has to wait for the slow load to leave the register
    task automatic test_back_to_back();
        issue_op(op_load, lw, wb_mem_data, 32'h84, 32'h0);
        issue_op(op_none, lw, wb_exe_data, 32'h0, 32'h0);
        if (ack_wait <= 1) begin
            errors++;
            $display("ERR at %0t ns: ack not held back, wait %0d", $time, ack_wait);
        end
        issue_op(op_load, lhu, wb_mem_data, 32'h92, 32'h0);
        check_next("b2b load");
        check_next("b2b non-mem");
        check_next("b2b half");
    endtask

    initial begin : watchdog
        #(max_ops * cycles_per_op * clk_period);
        $display("watchdog expired before all writebacks arrived");
        $display("Test failed");
        $finish;
    end

    initial begin : main
        rst          = 1'b1;
        issue_req_i  = 1'b0;
        kind_i       = op_none;
        width_i      = lw;
        wb_sel_i     = wb_exe_data;
        rd_i         = '0;
        reg_we_i     = 1'b0;
        pc_i         = '0;
        addr_i       = '0;
        exe_data_i   = '0;
        store_data_i = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_non_mem();
        test_stores();
        test_loads();
        test_traps();
        test_back_to_back();
        repeat (4) @(negedge clk);
        if (got_q.size() != 0) begin
            errors++;
            $display("writeback arrived with no matching issue");
        end
        $display("%0d errors after %0d operations", errors, next_order);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_lsu

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator.
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing -f tb.f --top-module tb_lsu \
    --Mdir build/obj_dir -o tb_lsu

./build/obj_dir/tb_lsu > build/sim.log 2>&1
cat build/sim.log

if grep -qx "Test passed" build/sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see build/sim.log"
    exit 1
fi

/* tb.f */
verilog/lsu_pkg.sv
verilog/dmem_req_if.sv
verilog/load_align.sv
verilog/exe_mem_stage.sv
verilog/dmem_port.sv
verilog/mem_wb_stage.sv
verilog/lsu_top.sv
dv/tb_dmem.sv
dv/tb_lsu.sv

/* verilog/dmem_port.sv */
`timescale 1ns/1ps

module dmem_port
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    dmem_req_if.port          mem,
    input  logic              busy_i,
    input  lsu_op_t           op_i,
    output logic              dmem_req_o,
    output logic              dmem_we_o,
    output logic [xlen-1:0]   dmem_addr_o,
    output logic [xlen-1:0]   dmem_wdata_o,
    output logic [nbytes-1:0] dmem_be_o,
    input  logic              dmem_ack_i,
    input  logic [xlen-1:0]   dmem_rdata_i,
    output logic              done_o,
    output logic [xlen-1:0]   rdata_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,  // req high, memory working
        st_wait_rel   // ack seen, waiting for it to drop
    } state_e;

    state_e          state;
    state_e          state_next;
    logic [xlen-1:0] rdata_q;
    logic            no_access;

    // nothing to fetch for plain or trapped ops
    assign no_access = busy_i && ((op_i.kind == op_none) || op_i.trap);

    always_comb begin : next_state
        state_next = state;
        case (state)
            st_idle:     if (mem.valid) state_next = st_wait_ack;
            st_wait_ack: if (dmem_ack_i) state_next = st_wait_rel;
            st_wait_rel: if (!dmem_ack_i) state_next = st_idle;
            default:     state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin : state_reg
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin : rdata_reg
        if (state == st_wait_ack && dmem_ack_i) begin
            rdata_q <= dmem_rdata_i;
        end
    end

    assign dmem_req_o   = (state == st_wait_ack);
    assign dmem_we_o    = mem.write;
    assign dmem_addr_o  = mem.addr;
    assign dmem_wdata_o = mem.wdata;
    assign dmem_be_o    = mem.byte_en;

    assign done_o    = no_access || (state == st_wait_rel && !dmem_ack_i);
    assign mem.done  = done_o;
    assign mem.rdata = rdata_q;
    assign rdata_o   = rdata_q;

endmodule : dmem_port

/* verilog/dmem_req_if.sv */
`timescale 1ns/1ps

interface dmem_req_if
    import lsu_pkg::*;
();
    logic              valid;    // held with stable fields until done
    logic              write;
    logic [xlen-1:0]   addr;     // word aligned
    logic [xlen-1:0]   wdata;    // already shifted into its lanes
    logic [nbytes-1:0] byte_en;
    logic              done;     // one-cycle completion pulse
    logic [xlen-1:0]   rdata;    // registered read data

    modport stage (
        output valid, write, addr, wdata, byte_en,
        input  done, rdata
    );

    modport port (
        input  valid, write, addr, wdata, byte_en,
        output done, rdata
    );

endinterface : dmem_req_if

/* verilog/exe_mem_stage.sv */
`timescale 1ns/1ps

module exe_mem_stage
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue_req_i,
    output logic                  issue_ack_o,
    input  lsu_op_e               kind_i,
    input  mem_width_e            width_i,
    input  wb_sel_e               wb_sel_i,
    input  logic [reg_addr_w-1:0] rd_i,
    input  logic                  reg_we_i,
    input  logic [xlen-1:0]       pc_i,
    input  logic [xlen-1:0]       addr_i,
    input  logic [xlen-1:0]       exe_data_i,
    input  logic [xlen-1:0]       store_data_i,
    dmem_req_if.stage             mem,
    output lsu_op_t               op_o,
    output logic                  busy_o
);

    logic [off_w-1:0]   offset;
    logic [xlen-1:0]    addr_aligned;
    logic [xlen-1:0]    wdata_shifted;
    logic [nbytes-1:0]  lanes;
    logic               trap;
    logic               is_mem;
    logic               store_ok;
    logic               capture;
    logic               ack_q;
    logic               op_full;
    logic               mem_valid;
    logic [order_w-1:0] order_cnt;
    logic [order_w-1:0] order_next;
    lsu_op_t            op_q;
    logic [xlen-1:0]    addr_q;
    logic [xlen-1:0]    wdata_q;

    assign offset        = addr_i[off_w-1:0];
    assign addr_aligned  = {addr_i[xlen-1:off_w], {off_w{1'b0}}};
    assign wdata_shifted = store_data_i << {offset, 3'b000};  // 8 * offset
    assign is_mem        = (kind_i == op_load) || (kind_i == op_store);
    assign store_ok      = (width_i == sb) || (width_i == sh) || (width_i == sw);
    assign order_next    = order_cnt + order_w'(1);

    // take a new op only when the register is free and the last ack has dropped
    assign capture = issue_req_i && !ack_q && !op_full;

    always_comb begin : lane_calc
        lanes = '0;
        trap  = 1'b0;
        if (is_mem) begin
            case (width_i)
                lb, lbu: lanes = nbytes'(1) << offset;
                lh, lhu: begin
                    lanes = nbytes'(3) << offset;
                    trap  = (offset == off_w'(nbytes - 1));  // half would leave the word
                end
                lw:      lanes = {nbytes{1'b1}} << offset;
                default: trap = 1'b1;  // undefined funct3
            endcase
            if (kind_i == op_store && !store_ok) begin
                trap = 1'b1;  // no unsigned stores
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin : ctrl_regs
        if (rst) begin
            ack_q     <= 1'b0;
            op_full   <= 1'b0;
            mem_valid <= 1'b0;
            order_cnt <= '1;  // first op gets order 0
        end else if (capture) begin
            ack_q     <= 1'b1;
            op_full   <= 1'b1;
            mem_valid <= is_mem && !trap;
            order_cnt <= order_next;
        end else begin
            if (!issue_req_i) begin
                ack_q <= 1'b0;  // falls one cycle after req
            end
            if (mem.done) begin
                op_full   <= 1'b0;
                mem_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin : op_reg
        if (capture) begin
            op_q.kind     <= kind_i;
            op_q.width    <= width_i;
            op_q.wb_sel   <= wb_sel_i;
            op_q.rd       <= rd_i;
            op_q.reg_we   <= reg_we_i;
            op_q.pc       <= pc_i;
            op_q.exe_data <= exe_data_i;
            op_q.byte_en  <= lanes;
            op_q.order    <= order_next;
            op_q.trap     <= trap;
            addr_q        <= addr_aligned;
            wdata_q       <= wdata_shifted;
        end
    end

    assign issue_ack_o = ack_q;
    assign busy_o      = op_full;
    assign op_o        = op_q;

    assign mem.valid   = mem_valid;
    assign mem.write   = (op_q.kind == op_store);
    assign mem.addr    = addr_q;
    assign mem.wdata   = wdata_q;
    assign mem.byte_en = op_q.byte_en;

endmodule : exe_mem_stage

/* verilog/load_align.sv */
`timescale 1ns/1ps

module load_align
    import lsu_pkg::*;
(
    input  logic [xlen-1:0]   rdata_i,
    input  logic [nbytes-1:0] byte_en_i,
    input  mem_width_e        width_i,
    output logic [xlen-1:0]   data_o
);

    logic [off_w-1:0] lane;
    logic [xlen-1:0]  shifted;

    // lowest enabled lane is where the byte or half starts
    always_comb begin : lane_find
        lane = '0;
        for (int i = nbytes - 1; i >= 0; i--) begin
            if (byte_en_i[i]) begin
                lane = off_w'(i);
            end
        end
    end

    assign shifted = rdata_i >> {lane, 3'b000};

    always_comb begin : extend
        case (width_i)
            lb:      data_o = {{(xlen - 8){shifted[7]}}, shifted[7:0]};
            lbu:     data_o = {{(xlen - 8){1'b0}}, shifted[7:0]};
            lh:      data_o = {{(xlen - 16){shifted[15]}}, shifted[15:0]};
            lhu:     data_o = {{(xlen - 16){1'b0}}, shifted[15:0]};
            default: data_o = rdata_i;  // full word
        endcase
    end

endmodule : load_align

/* verilog/lsu_pkg.sv */
package lsu_pkg;

    localparam int xlen       = 32;
    localparam int nbytes     = xlen / 8;        // 4 byte lanes
    localparam int reg_addr_w = 5;
    localparam int order_w    = 64;
    localparam int off_w      = $clog2(nbytes);  // byte offset within a word

    // operation kind coming from execute
    typedef enum logic [1:0] {
        op_none  = 2'b00,
        op_load  = 2'b01,
        op_store = 2'b10
    } lsu_op_e;

    // funct3 of loads, stores reuse the signed encodings
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } mem_width_e;

    localparam mem_width_e sb = lb;
    localparam mem_width_e sh = lh;
    localparam mem_width_e sw = lw;

    // writeback source select
    typedef enum logic [1:0] {
        wb_exe_data  = 2'b00,
        wb_mem_data  = 2'b01,
        wb_pc_plus_4 = 2'b10
    } wb_sel_e;

    // everything that travels from execute/memory to writeback
    typedef struct packed {
        lsu_op_e               kind;
        mem_width_e            width;
        wb_sel_e               wb_sel;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_we;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       exe_data;  // alu result from execute
        logic [nbytes-1:0]     byte_en;   // lanes touched in memory
        logic [order_w-1:0]    order;     // commit order number
        logic                  trap;      // illegal width or misaligned half
    } lsu_op_t;

endpackage : lsu_pkg

/* verilog/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue_req_i,
    output logic                  issue_ack_o,
    input  lsu_op_e               kind_i,
    input  mem_width_e            width_i,
    input  wb_sel_e               wb_sel_i,
    input  logic [reg_addr_w-1:0] rd_i,
    input  logic                  reg_we_i,
    input  logic [xlen-1:0]       pc_i,
    input  logic [xlen-1:0]       addr_i,
    input  logic [xlen-1:0]       exe_data_i,
    input  logic [xlen-1:0]       store_data_i,
    output logic                  dmem_req_o,
    output logic                  dmem_we_o,
    output logic [xlen-1:0]       dmem_addr_o,
    output logic [xlen-1:0]       dmem_wdata_o,
    output logic [nbytes-1:0]     dmem_be_o,
    input  logic                  dmem_ack_i,
    input  logic [xlen-1:0]       dmem_rdata_i,
    output logic                  wb_valid_o,
    output logic                  wb_we_o,
    output logic [reg_addr_w-1:0] wb_rd_o,
    output logic [xlen-1:0]       wb_data_o,
    output logic [order_w-1:0]    wb_order_o,
    output logic                  wb_trap_o
);

    lsu_op_t         op;
    logic            busy;
    logic            op_valid;   // op finished its memory phase
    logic [xlen-1:0] mem_rdata;

    dmem_req_if i_mem ();

    exe_mem_stage i_exe_mem (
        .clk          (clk),
        .rst          (rst),
        .issue_req_i  (issue_req_i),
        .issue_ack_o  (issue_ack_o),
        .kind_i       (kind_i),
        .width_i      (width_i),
        .wb_sel_i     (wb_sel_i),
        .rd_i         (rd_i),
        .reg_we_i     (reg_we_i),
        .pc_i         (pc_i),
        .addr_i       (addr_i),
        .exe_data_i   (exe_data_i),
        .store_data_i (store_data_i),
        .mem          (i_mem.stage),
        .op_o         (op),
        .busy_o       (busy)
    );

    dmem_port i_dmem_port (
        .clk          (clk),
        .rst          (rst),
        .mem          (i_mem.port),
        .busy_i       (busy),
        .op_i         (op),
        .dmem_req_o   (dmem_req_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_be_o    (dmem_be_o),
        .dmem_ack_i   (dmem_ack_i),
        .dmem_rdata_i (dmem_rdata_i),
        .done_o       (op_valid),
        .rdata_o      (mem_rdata)
    );

    mem_wb_stage i_mem_wb (
        .clk        (clk),
        .rst        (rst),
        .op_valid_i (op_valid),
        .op_i       (op),
        .rdata_i    (mem_rdata),
        .wb_valid_o (wb_valid_o),
        .wb_we_o    (wb_we_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o),
        .wb_order_o (wb_order_o),
        .wb_trap_o  (wb_trap_o)
    );

endmodule : lsu_top

/* verilog/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  op_valid_i,
    input  lsu_op_t               op_i,
    input  logic [xlen-1:0]       rdata_i,
    output logic                  wb_valid_o,
    output logic                  wb_we_o,
    output logic [reg_addr_w-1:0] wb_rd_o,
    output logic [xlen-1:0]       wb_data_o,
    output logic [order_w-1:0]    wb_order_o,
    output logic                  wb_trap_o
);

    logic [xlen-1:0] ld_data;
    logic [xlen-1:0] wb_data_next;

    load_align i_load_align (
        .rdata_i   (rdata_i),
        .byte_en_i (op_i.byte_en),
        .width_i   (op_i.width),
        .data_o    (ld_data)
    );

    always_comb begin : wb_mux
        case (op_i.wb_sel)
            wb_mem_data:  wb_data_next = ld_data;
            wb_pc_plus_4: wb_data_next = op_i.pc + xlen'(4);  // link address
            default:      wb_data_next = op_i.exe_data;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin : valid_reg
        if (rst) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= op_valid_i;  // single-cycle pulse per op
        end
    end

    always_ff @(posedge clk) begin : wb_reg
        if (op_valid_i) begin
            wb_data_o  <= wb_data_next;
            wb_rd_o    <= op_i.rd;
            wb_we_o    <= op_i.reg_we && !op_i.trap;  // trapped ops never write
            wb_order_o <= op_i.order;
            wb_trap_o  <= op_i.trap;
        end
    end

endmodule : mem_wb_stage
